// File: cpu_alu.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_alu
  import cpu_pkg::*;
(
  input  word_t     in1_i,
  input  word_t     in2_i,
  input  alu_func_t func_i,
  output word_t     out_o,
  output logic      carry_o,
  output logic      negative_o,
  output logic      overflow_o,
  output logic      zero_o
);

  logic [32:0] wide; // carry out in bit 32

  always_comb
  begin
    wide       = '0;
    carry_o    = 1'b0;
    overflow_o = 1'b0;
    case (func_i)
      ALU_ADD:
      begin
        wide       = {1'b0, in1_i} + {1'b0, in2_i};
        carry_o    = wide[32];
        overflow_o = (in1_i[31] == in2_i[31]) && (wide[31] != in1_i[31]);
      end
      ALU_SUB:
      begin
        wide       = {1'b0, in1_i} - {1'b0, in2_i};
        carry_o    = wide[32]; // borrow
        overflow_o = (in1_i[31] != in2_i[31]) && (wide[31] != in1_i[31]);
      end
      ALU_AND: wide[31:0] = in1_i & in2_i;
      ALU_OR:  wide[31:0] = in1_i | in2_i;
      ALU_XOR: wide[31:0] = in1_i ^ in2_i;
      ALU_SHL: wide[31:0] = in1_i << in2_i[4:0];
      ALU_SHR: wide[31:0] = in1_i >> in2_i[4:0]; // logical
      default: wide = '0;
    endcase
  end

  assign out_o      = wide[31:0];
  assign negative_o = wide[31];
  assign zero_o     = (wide[31:0] == '0);

endmodule

`default_nettype wire

// File: cpu_control.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_control
  import cpu_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_i,
  cpu_ctrl_if.decode      ctrl,
  input  logic            ins_ack_i,
  input  logic            dat_ack_i,
  output logic            ins_cyc_o,
  output logic            ins_stb_o,
  output logic            dat_cyc_o,
  output logic            dat_stb_o,
  output logic            dat_we_o,
  output logic            halt_o
);

  cpu_state_t state;
  cpu_state_t state_next;
  instr_t     instr;
  logic       is_load;
  logic       is_store;
  logic       taken;
  logic       ins_req;
  logic       dat_req;
  logic       dat_wr;
  logic       ins_done;
  logic       dat_done;

  assign instr    = instr_t'(ctrl.ir);
  assign is_load  = (instr.opcode == OP_LD) || (instr.opcode == OP_LDB);
  assign is_store = (instr.opcode == OP_ST) || (instr.opcode == OP_STB);
  assign ins_done = ins_req && ins_ack_i; // ack only counts inside our own cycle
  assign dat_done = dat_req && dat_ack_i;

  always_comb
  begin
    case (cond_t'(instr.ra[1:0]))
      COND_EQ: taken = ctrl.ccr[CCR_ZERO];
      COND_NE: taken = !ctrl.ccr[CCR_ZERO];
      COND_LT: taken = ctrl.ccr[CCR_LT];
      default: taken = 1'b1;
    endcase
  end

  // selects that follow the instruction, not the state
  assign ctrl.alu_func       = (instr.opcode == OP_ALU) ? alu_func_t'(instr.imm[2:0]) : ALU_ADD;
  assign ctrl.alu2_sel       = (instr.opcode == OP_ALU) ? ALU2_B : ALU2_IMM;
  assign ctrl.reg_read1      = instr.rb;
  assign ctrl.reg_read2      = is_store ? instr.ra : instr.rc; // store data in ra
  assign ctrl.reg_write_addr = instr.ra;
  assign ctrl.byte_access    = (instr.opcode == OP_LDB) || (instr.opcode == OP_STB);
  assign ctrl.reg_sel        = (instr.opcode == OP_LDI) ? REG_IMM :
                               is_load ? REG_MDR : REG_ALU;

  always_comb
  begin
    state_next     = state;
    ctrl.pc_sel    = PC_HOLD;
    ctrl.ir_write  = 1'b0;
    ctrl.a_write   = 1'b0;
    ctrl.b_write   = 1'b0;
    ctrl.ccr_write = 1'b0;
    ctrl.mar_write = 1'b0;
    ctrl.mdr_sel   = MDR_HOLD;
    ctrl.reg_write = 1'b0;
    case (state)
      S_FETCH:
      begin
        if (ins_done)
        begin
          ctrl.ir_write = 1'b1;
          ctrl.pc_sel   = PC_NEXT;
          state_next    = S_DECODE;
        end
      end
      S_DECODE:
      begin
        case (instr.opcode)
          OP_ALU, OP_LDI, OP_LD, OP_LDB, OP_ST, OP_STB, OP_BR:
          begin
            ctrl.a_write = 1'b1;
            ctrl.b_write = 1'b1;
            state_next   = S_EXEC;
          end
          default: state_next = S_HALT; // OP_HALT and illegal opcodes
        endcase
      end
      S_EXEC:
      begin
        case (instr.opcode)
          OP_ALU:
          begin
            ctrl.ccr_write = 1'b1;
            state_next     = S_WB;
          end
          OP_LDI: state_next = S_WB;
          OP_LD, OP_LDB, OP_ST, OP_STB:
          begin
            ctrl.mar_write = 1'b1; // rb + imm
            if (is_store)
              ctrl.mdr_sel = MDR_B;
            state_next = S_MEM;
          end
          OP_BR:
          begin
            if (taken)
              ctrl.pc_sel = PC_REL;
            state_next = S_FETCH;
          end
          default: state_next = S_HALT;
        endcase
      end
      S_MEM:
      begin
        if (dat_done)
        begin
          if (is_load)
          begin
            ctrl.mdr_sel = MDR_DBUS;
            state_next   = S_WB;
          end
          else
            state_next = S_FETCH;
        end
      end
      S_WB:
      begin
        ctrl.reg_write = 1'b1;
        state_next     = S_FETCH;
      end
      default: state_next = S_HALT; // stays until reset
    endcase
  end

  // bus strobes come from flops so they are low out of reset
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state   <= S_FETCH;
      ins_req <= 1'b0;
      dat_req <= 1'b0;
      dat_wr  <= 1'b0;
    end
    else
    begin
      state   <= state_next;
      ins_req <= (state_next == S_FETCH);
      dat_req <= (state_next == S_MEM);
      dat_wr  <= (state_next == S_MEM) && is_store;
    end
  end

  assign ins_cyc_o = ins_req;
  assign ins_stb_o = ins_req;
  assign dat_cyc_o = dat_req;
  assign dat_stb_o = dat_req;
  assign dat_we_o  = dat_wr;
  assign halt_o    = (state == S_HALT);

  // one access at a time across both buses
  a_one_bus: assert property (@(posedge clk_i) disable iff (rst_i)
    !((ins_cyc_o || ins_stb_o) && (dat_cyc_o || dat_stb_o)));

  a_halt_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
    halt_o |=> halt_o);

endmodule

`default_nettype wire

// File: cpu_core.f
cpu_pkg.sv
cpu_ctrl_if.sv
cpu_alu.sv
cpu_regfile.sv
cpu_lane.sv
cpu_control.sv
cpu_core.sv
tb_cpu_core.sv

// File: cpu_core.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_core
  import cpu_pkg::*;
#(
  parameter word_t START_ADDR = 32'h0000_0000
)
(
  input  logic  clk_i,
  input  logic  rst_i,
  output logic  ins_cyc_o,
  output logic  ins_stb_o,
  output word_t ins_adr_o,
  input  word_t ins_dat_i,
  input  logic  ins_ack_i,
  output logic  dat_cyc_o,
  output logic  dat_stb_o,
  output logic  dat_we_o,
  output word_t dat_adr_o,
  output sel_t  dat_sel_o,
  output word_t dat_dat_o,
  input  word_t dat_dat_i,
  input  logic  dat_ack_i,
  output logic  halt_o
);

  cpu_ctrl_if ctrl ();

  word_t pc, pc_next;
  word_t ir;
  word_t mar, mdr, mdr_next;
  word_t a, b;
  ccr_t  ccr, ccr_next;
  word_t ir_sval;
  word_t alu_in2, alu_out;
  word_t reg_data_in, reg_data1, reg_data2;
  word_t lane_load;
  logic  alu_carry, alu_negative, alu_overflow, alu_zero;

  assign ctrl.ir  = ir;
  assign ctrl.ccr = ccr;

  assign ir_sval   = {{16{ir[15]}}, ir[15:0]};
  assign ins_adr_o = pc;
  assign dat_adr_o = {mar[31:2], 2'b00}; // lanes picked by dat_sel_o

  always_comb
  begin
    case (ctrl.pc_sel)
      PC_NEXT: pc_next = pc + 32'd4;
      PC_REL:  pc_next = pc + {ir_sval[29:0], 2'b00} - 32'd4; // pc already advanced
      default: pc_next = pc;
    endcase
    case (ctrl.mdr_sel)
      MDR_B:    mdr_next = b;
      MDR_DBUS: mdr_next = lane_load;
      default:  mdr_next = mdr;
    endcase
    case (ctrl.reg_sel)
      REG_MDR: reg_data_in = mdr;
      REG_IMM: reg_data_in = ir_sval;
      default: reg_data_in = alu_out;
    endcase
    alu_in2  = (ctrl.alu2_sel == ALU2_B) ? b : ir_sval;
    ccr_next = ctrl.ccr_write ? {alu_carry, alu_negative ^ alu_overflow, alu_zero} : ccr;
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      pc  <= START_ADDR;
      ir  <= '0;
      ccr <= '0;
    end
    else
    begin
      pc  <= pc_next;
      ccr <= ccr_next;
      if (ctrl.ir_write)
        ir <= ins_dat_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    mdr <= mdr_next;
    if (ctrl.mar_write)
      mar <= alu_out;
    if (ctrl.a_write)
      a <= reg_data1;
    if (ctrl.b_write)
      b <= reg_data2;
  end

  cpu_control i_cpu_control (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .ctrl      (ctrl),
    .ins_ack_i (ins_ack_i),
    .dat_ack_i (dat_ack_i),
    .ins_cyc_o (ins_cyc_o),
    .ins_stb_o (ins_stb_o),
    .dat_cyc_o (dat_cyc_o),
    .dat_stb_o (dat_stb_o),
    .dat_we_o  (dat_we_o),
    .halt_o    (halt_o)
  );

  cpu_alu i_cpu_alu (
    .in1_i      (a),
    .in2_i      (alu_in2),
    .func_i     (ctrl.alu_func),
    .out_o      (alu_out),
    .carry_o    (alu_carry),
    .negative_o (alu_negative),
    .overflow_o (alu_overflow),
    .zero_o     (alu_zero)
  );

  cpu_regfile i_cpu_regfile (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .read1_i      (ctrl.reg_read1),
    .read2_i      (ctrl.reg_read2),
    .write_addr_i (ctrl.reg_write_addr),
    .write_data_i (reg_data_in),
    .write_en_i   (ctrl.reg_write),
    .data1_o      (reg_data1),
    .data2_o      (reg_data2)
  );

  cpu_lane i_cpu_lane (
    .byte_i  (ctrl.byte_access),
    .align_i (mar[1:0]),
    .store_i (mdr),
    .load_i  (dat_dat_i),
    .sel_o   (dat_sel_o),
    .store_o (dat_dat_o),
    .load_o  (lane_load)
  );

  a_word_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
    (dat_stb_o && !ctrl.byte_access) |-> (mar[1:0] == 2'b00));

endmodule

`default_nettype wire

// File: cpu_ctrl_if.sv
`timescale 1ns/100ps
`default_nettype none

interface cpu_ctrl_if
  import cpu_pkg::*;
();

  pc_sel_t   pc_sel;
  logic      ir_write;
  logic      a_write;
  logic      b_write;
  alu_func_t alu_func;
  alu2_sel_t alu2_sel;
  logic      ccr_write;
  logic      mar_write;
  mdr_sel_t  mdr_sel;
  reg_sel_t  reg_sel;
  logic      reg_write;
  reg_addr_t reg_read1;
  reg_addr_t reg_read2;
  reg_addr_t reg_write_addr;
  logic      byte_access;
  word_t     ir;  // read back by control
  ccr_t      ccr;

  modport decode (
    output pc_sel, ir_write, a_write, b_write, alu_func, alu2_sel, ccr_write,
           mar_write, mdr_sel, reg_sel, reg_write, reg_read1, reg_read2,
           reg_write_addr, byte_access,
    input  ir, ccr
  );

  modport datapath (
    input  pc_sel, ir_write, a_write, b_write, alu_func, alu2_sel, ccr_write,
           mar_write, mdr_sel, reg_sel, reg_write, reg_read1, reg_read2,
           reg_write_addr, byte_access,
    output ir, ccr
  );

endinterface

`default_nettype wire

// File: cpu_lane.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_lane
  import cpu_pkg::*;
(
  input  logic       byte_i,
  input  logic [1:0] align_i,
  input  word_t      store_i,
  input  word_t      load_i,
  output sel_t       sel_o,
  output word_t      store_o,
  output word_t      load_o
);

  logic [4:0] shift; // bit offset of the addressed lane

  assign shift = {align_i, 3'b000};

  always_comb
  begin
    if (byte_i)
    begin
      sel_o   = sel_t'(4'b0001 << align_i);
      store_o = {24'h000000, store_i[7:0]} << shift; // other lanes zero
      load_o  = {24'h000000, load_i[shift +: 8]};
    end
    else
    begin
      sel_o   = 4'hf;
      store_o = store_i;
      load_o  = load_i;
    end
  end

endmodule

`default_nettype wire

// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  sel_t;
  typedef logic [3:0]  reg_addr_t;
  typedef logic [2:0]  ccr_t;

  // ccr bit positions
  localparam int CCR_CARRY = 2;
  localparam int CCR_LT    = 1; // negative xor overflow
  localparam int CCR_ZERO  = 0;

  typedef enum logic [3:0] {
    OP_ALU  = 4'h0,
    OP_LDI  = 4'h1,
    OP_LD   = 4'h2,
    OP_LDB  = 4'h3,
    OP_ST   = 4'h4,
    OP_STB  = 4'h5,
    OP_BR   = 4'h6,
    OP_HALT = 4'h7
  } opcode_t; // 4'h8 and up are illegal

  typedef struct packed {
    opcode_t     opcode; // 31:28
    reg_addr_t   ra;     // 27:24, condition for OP_BR
    reg_addr_t   rb;     // 23:20
    reg_addr_t   rc;     // 19:16
    logic [15:0] imm;    // signed, alu function in 2:0
  } instr_t;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SHL = 3'd5,
    ALU_SHR = 3'd6
  } alu_func_t;

  typedef enum logic [1:0] {
    COND_ALWAYS = 2'd0,
    COND_EQ     = 2'd1,
    COND_NE     = 2'd2,
    COND_LT     = 2'd3
  } cond_t;

  typedef enum logic [1:0] {PC_HOLD, PC_NEXT, PC_REL} pc_sel_t;
  typedef enum logic {ALU2_B, ALU2_IMM} alu2_sel_t;
  typedef enum logic [1:0] {REG_ALU, REG_MDR, REG_IMM} reg_sel_t;
  typedef enum logic [1:0] {MDR_HOLD, MDR_B, MDR_DBUS} mdr_sel_t;

  typedef enum logic [2:0] {
    S_FETCH,
    S_DECODE,
    S_EXEC,
    S_MEM,
    S_WB,
    S_HALT
  } cpu_state_t;

endpackage

`default_nettype wire

// File: cpu_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_regfile
  import cpu_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  reg_addr_t read1_i,
  input  reg_addr_t read2_i,
  input  reg_addr_t write_addr_i,
  input  word_t     write_data_i,
  input  logic      write_en_i,
  output word_t     data1_o,
  output word_t     data2_o
);

  word_t regs [16];

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < 16; i++)
        regs[i] <= '0;
    end
    else if (write_en_i && (write_addr_i != '0))
      regs[write_addr_i] <= write_data_i; // r0 stays zero
  end

  assign data1_o = (read1_i == '0) ? '0 : regs[read1_i];
  assign data2_o = (read2_i == '0) ? '0 : regs[read2_i];

  a_waddr_known: assert property (@(posedge clk_i) disable iff (rst_i)
    write_en_i |-> !$isunknown(write_addr_i));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_cpu_core -f cpu_core.f -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
  echo "run failed, see sim.log"
  exit 1
fi
echo "run passed"
exit 0

// File: tb_cpu_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_core
  import cpu_pkg::*;
();

  localparam int          WAIT_LIMIT = 400; // cycles per wait loop
  localparam int          QUIET_CYCLES = 50;
  localparam int          DATA_WORD = 64;
  localparam logic [15:0] DATA_OFS = 16'h0100;
  localparam word_t       DATA_BASE = 32'h0000_0100;
  localparam word_t       LFSR_TAPS = 32'h8020_0003;
  localparam logic [15:0] MARKER = 16'h0bad;

  typedef struct {
    string       name;
    word_t [7:0] prog;
    word_t [3:0] data;      // preloaded at DATA_BASE
    logic        has_store; // first data write expected
    word_t       exp_adr;
    word_t       exp_dat;
    sel_t        exp_sel;
  } test_t;

  logic  clk_i = 1'b0;
  logic  rst_i;
  logic  ins_cyc_o, ins_stb_o;
  word_t ins_adr_o;
  word_t ins_dat_i = '0;
  logic  ins_ack_i = 1'b0;
  logic  dat_cyc_o, dat_stb_o, dat_we_o;
  word_t dat_adr_o, dat_dat_o;
  sel_t  dat_sel_o;
  word_t dat_dat_i = '0;
  logic  dat_ack_i = 1'b0;
  logic  halt_o;

  test_t      tests[$];
  int         cur_idx = 0;
  int         error_count = 0;
  word_t      mem [256];
  word_t      lfsr = 32'h2a79_0faf;
  logic       busy = 1'b0;
  logic [1:0] wait_cnt = 2'd0;
  int         wr_count = 0;
  word_t      wr_adr, wr_dat;
  sel_t       wr_sel;

  cpu_core #(
    .START_ADDR (32'h0000_0000)
  ) i_cpu_core (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .ins_cyc_o (ins_cyc_o),
    .ins_stb_o (ins_stb_o),
    .ins_adr_o (ins_adr_o),
    .ins_dat_i (ins_dat_i),
    .ins_ack_i (ins_ack_i),
    .dat_cyc_o (dat_cyc_o),
    .dat_stb_o (dat_stb_o),
    .dat_we_o  (dat_we_o),
    .dat_adr_o (dat_adr_o),
    .dat_sel_o (dat_sel_o),
    .dat_dat_o (dat_dat_o),
    .dat_dat_i (dat_dat_i),
    .dat_ack_i (dat_ack_i),
    .halt_o    (halt_o)
  );

  always #5 clk_i = ~clk_i;

  function automatic word_t lfsr_step(input word_t s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  function automatic word_t sext16(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  function automatic word_t ins(input opcode_t op, input reg_addr_t ra, input reg_addr_t rb,
                                input reg_addr_t rc, input logic [15:0] imm);
    return {op, ra, rb, rc, imm};
  endfunction

  task automatic draw_delay(output logic [1:0] d);
    for (int k = 0; k < 2; k++)
    begin
      d[k] = lfsr[0]; // one step per bit
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic load_memory(input int n);
    for (int i = 0; i < 256; i++)
      mem[i] = 32'hf111_0000 + 32'(i * 4); // byte address in the low half
    for (int i = 0; i < 8; i++)
      mem[i] = tests[n].prog[i];
    for (int i = 0; i < 4; i++)
      mem[DATA_WORD + i] = tests[n].data[i];
  endtask

  task automatic stop_run(input string msg);
    error_count = error_count + 1;
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // memory model for both buses, one access at a time
  always @(posedge clk_i)
  begin
    #1;
    if ((ins_stb_o && !ins_cyc_o) || (dat_stb_o && !dat_cyc_o))
      stop_run("bus strobe raised without its cyc");
    else if (rst_i)
    begin
      load_memory(cur_idx);
      ins_ack_i = 1'b0;
      dat_ack_i = 1'b0;
      busy      = 1'b0;
    end
    else if (ins_ack_i || dat_ack_i)
    begin
      ins_ack_i = 1'b0; // ack was sampled on this edge
      dat_ack_i = 1'b0;
      busy      = 1'b0;
    end
    else if (ins_stb_o || dat_stb_o)
    begin
      if (!busy)
      begin
        busy = 1'b1;
        draw_delay(wait_cnt);
      end
      if (wait_cnt != 2'd0)
        wait_cnt = wait_cnt - 2'd1;
      else if (ins_stb_o)
      begin
        ins_dat_i = mem[ins_adr_o[9:2]];
        ins_ack_i = 1'b1;
      end
      else
      begin
        dat_ack_i = 1'b1;
        if (dat_we_o)
        begin
          for (int j = 0; j < 4; j++)
            if (dat_sel_o[j])
              mem[dat_adr_o[9:2]][8*j +: 8] = dat_dat_o[8*j +: 8];
          wr_adr   = dat_adr_o;
          wr_dat   = dat_dat_o;
          wr_sel   = dat_sel_o;
          wr_count = wr_count + 1;
        end
        else
          dat_dat_i = mem[dat_adr_o[9:2]];
      end
    end
  end

  task automatic check_word(input string test_name, input string field, input word_t exp,
                            input word_t act);
    if (act !== exp)
      stop_run($sformatf("[ERROR] %s %s: expected %08h, actual %08h",
                         test_name, field, exp, act));
  endtask

  task automatic check_sel(input string test_name, input string field, input sel_t exp,
                           input sel_t act);
    if (act !== exp)
      stop_run($sformatf("[ERROR] %s %s: expected %h, actual %h", test_name, field, exp, act));
  endtask

  task automatic check_bit(input string test_name, input string field, input logic exp,
                           input logic act);
    if (act !== exp)
      stop_run($sformatf("[ERROR] %s %s: expected %b, actual %b", test_name, field, exp, act));
  endtask

  function automatic test_t blank_entry(input string name);
    test_t t;
    t.name      = name;
    t.prog      = {8{ins(OP_HALT, 4'd0, 4'd0, 4'd0, 16'd0)}};
    t.data      = '0;
    t.has_store = 1'b1;
    t.exp_adr   = DATA_BASE;
    t.exp_dat   = '0;
    t.exp_sel   = 4'hf;
    return t;
  endfunction

  task automatic add_alu(input string name, input alu_func_t f, input logic [15:0] v1,
                         input logic [15:0] v2, input word_t expected);
    test_t t;
    t = blank_entry(name);
    t.prog[0] = ins(OP_LDI, 4'd1, 4'd0, 4'd0, v1);
    t.prog[1] = ins(OP_LDI, 4'd2, 4'd0, 4'd0, v2);
    t.prog[2] = ins(OP_ALU, 4'd3, 4'd1, 4'd2, {13'd0, f});
    t.prog[3] = ins(OP_ST, 4'd3, 4'd0, 4'd0, DATA_OFS);
    t.exp_dat = expected;
    tests.push_back(t);
  endtask

  task automatic add_branch(input string name, input cond_t c, input logic [15:0] v1,
                            input logic [15:0] v2);
    test_t t;
    logic  taken;
    word_t diff;
    t    = blank_entry(name);
    diff = sext16(v1) - sext16(v2);
    case (c)
      COND_EQ: taken = (diff == '0);
      COND_NE: taken = (diff != '0);
      COND_LT: taken = ($signed(sext16(v1)) < $signed(sext16(v2)));
      default: taken = 1'b1;
    endcase
    t.prog[0] = ins(OP_LDI, 4'd4, 4'd0, 4'd0, MARKER);
    t.prog[1] = ins(OP_LDI, 4'd1, 4'd0, 4'd0, v1);
    t.prog[2] = ins(OP_LDI, 4'd2, 4'd0, 4'd0, v2);
    t.prog[3] = ins(OP_ALU, 4'd3, 4'd1, 4'd2, {13'd0, ALU_SUB});
    t.prog[4] = ins(OP_BR, {2'b00, c}, 4'd0, 4'd0, 16'd2); // over the marker store
    t.prog[5] = ins(OP_ST, 4'd4, 4'd0, 4'd0, DATA_OFS);
    t.prog[6] = ins(OP_ST, 4'd1, 4'd0, 4'd0, DATA_OFS + 16'd4);
    t.exp_adr = taken ? DATA_BASE + 32'd4 : DATA_BASE;
    t.exp_dat = taken ? sext16(v1) : sext16(MARKER);
    tests.push_back(t);
  endtask

  task automatic build_table();
    test_t t;
    add_alu("alu_add", ALU_ADD, 16'h8765, 16'h0123, sext16(16'h8765) + sext16(16'h0123));
    add_alu("alu_sub", ALU_SUB, 16'h0123, 16'h8765, sext16(16'h0123) - sext16(16'h8765));
    add_alu("alu_and", ALU_AND, 16'h8765, 16'h0f3c, sext16(16'h8765) & sext16(16'h0f3c));
    add_alu("alu_or", ALU_OR, 16'h8765, 16'h0f3c, sext16(16'h8765) | sext16(16'h0f3c));
    add_alu("alu_xor", ALU_XOR, 16'h8765, 16'h0f3c, sext16(16'h8765) ^ sext16(16'h0f3c));
    // shift amount is the low five bits, so 0x24 shifts by 4
    add_alu("alu_shl", ALU_SHL, 16'h8765, 16'h0024, sext16(16'h8765) << 4);
    add_alu("alu_shr", ALU_SHR, 16'h8765, 16'h0024, sext16(16'h8765) >> 4);
    t = blank_entry("word_copy");
    t.data[0] = 32'hcafe_f00d;
    t.prog[0] = ins(OP_LD, 4'd1, 4'd0, 4'd0, DATA_OFS);
    t.prog[1] = ins(OP_ST, 4'd1, 4'd0, 4'd0, DATA_OFS + 16'h0080);
    t.exp_adr = DATA_BASE + 32'h80;
    t.exp_dat = 32'hcafe_f00d;
    tests.push_back(t);
    t = blank_entry("word_copy_base_reg");
    t.data[1] = 32'h1357_9bdf;
    t.prog[0] = ins(OP_LDI, 4'd2, 4'd0, 4'd0, DATA_OFS);
    t.prog[1] = ins(OP_LD, 4'd1, 4'd2, 4'd0, 16'd4);
    t.prog[2] = ins(OP_ST, 4'd1, 4'd2, 4'd0, 16'h0080);
    t.exp_adr = DATA_BASE + 32'h80;
    t.exp_dat = 32'h1357_9bdf;
    tests.push_back(t);
    for (int k = 0; k < 4; k++)
    begin
      t = blank_entry($sformatf("stb_align%0d", k));
      t.prog[0] = ins(OP_LDI, 4'd1, 4'd0, 4'd0, 16'hf0c3); // only c3 goes out
      t.prog[1] = ins(OP_STB, 4'd1, 4'd0, 4'd0, DATA_OFS + 16'(k));
      t.exp_dat = 32'h0000_00c3 << (8 * k);
      t.exp_sel = sel_t'(4'b0001 << k);
      tests.push_back(t);
      t = blank_entry($sformatf("ldb_align%0d", k));
      t.data[0] = 32'h8899_aabb;
      t.prog[0] = ins(OP_LDB, 4'd1, 4'd0, 4'd0, DATA_OFS + 16'(k));
      t.prog[1] = ins(OP_ST, 4'd1, 4'd0, 4'd0, DATA_OFS + 16'h0080);
      t.exp_adr = DATA_BASE + 32'h80;
      t.exp_dat = (32'h8899_aabb >> (8 * k)) & 32'h0000_00ff;
      tests.push_back(t);
    end
    add_branch("br_eq_true", COND_EQ, 16'd5, 16'd5);
    add_branch("br_eq_false", COND_EQ, 16'd5, 16'd7);
    add_branch("br_ne_true", COND_NE, 16'd5, 16'd7);
    add_branch("br_ne_false", COND_NE, 16'd5, 16'd5);
    add_branch("br_lt_true", COND_LT, 16'hfffd, 16'd2);
    add_branch("br_lt_false", COND_LT, 16'd2, 16'hfffd);
    add_branch("br_lt_equal", COND_LT, 16'd5, 16'd5);
    add_branch("br_always", COND_ALWAYS, 16'd5, 16'd7);
    t = blank_entry("r0_ignored");
    t.prog[0] = ins(OP_LDI, 4'd0, 4'd0, 4'd0, 16'h55aa);
    t.prog[1] = ins(OP_ST, 4'd0, 4'd0, 4'd0, DATA_OFS);
    tests.push_back(t);
    t = blank_entry("halt_op");
    t.has_store = 1'b0;
    t.prog[0]   = ins(OP_LDI, 4'd1, 4'd0, 4'd0, 16'h0077);
    t.prog[2]   = ins(OP_ST, 4'd1, 4'd0, 4'd0, DATA_OFS); // must never run
    tests.push_back(t);
    t = blank_entry("illegal_op");
    t.has_store = 1'b0;
    t.prog[0]   = ins(OP_LDI, 4'd1, 4'd0, 4'd0, 16'h0077);
    t.prog[1]   = 32'h9000_0000;
    t.prog[2]   = ins(OP_ST, 4'd1, 4'd0, 4'd0, DATA_OFS);
    tests.push_back(t);
  endtask

  task automatic wait_first_write(input string test_name, input int base);
    int cycles;
    cycles = 0;
    while (wr_count == base)
    begin
      if (cycles >= WAIT_LIMIT)
        stop_run($sformatf("test %s: no data write within %0d cycles", test_name, cycles));
      else
      begin
        @(negedge clk_i);
        cycles = cycles + 1;
      end
    end
  endtask

  task automatic wait_halt(input string test_name);
    int cycles;
    cycles = 0;
    while (!halt_o)
    begin
      if (cycles >= WAIT_LIMIT)
        stop_run($sformatf("test %s: core did not halt within %0d cycles", test_name, cycles));
      else
      begin
        @(negedge clk_i);
        cycles = cycles + 1;
      end
    end
  endtask

  task automatic check_quiet(input string test_name);
    for (int c = 0; c < QUIET_CYCLES; c++)
    begin
      @(negedge clk_i);
      if (ins_cyc_o || ins_stb_o || dat_cyc_o || dat_stb_o)
        stop_run($sformatf("test %s: bus cycle seen after halt", test_name));
      else if (!halt_o)
        stop_run($sformatf("test %s: halt_o fell without reset", test_name));
    end
  endtask

  task automatic run_entry(input int n);
    int base;
    @(posedge clk_i);
    #1;
    cur_idx = n;
    rst_i   = 1'b1;
    repeat (5) @(posedge clk_i);
    #1;
    check_bit(tests[n].name, "ins_cyc_o in reset", 1'b0, ins_cyc_o);
    check_bit(tests[n].name, "ins_stb_o in reset", 1'b0, ins_stb_o);
    check_bit(tests[n].name, "dat_cyc_o in reset", 1'b0, dat_cyc_o);
    check_bit(tests[n].name, "dat_stb_o in reset", 1'b0, dat_stb_o);
    check_bit(tests[n].name, "dat_we_o in reset", 1'b0, dat_we_o);
    check_bit(tests[n].name, "halt_o in reset", 1'b0, halt_o);
    rst_i = 1'b0;
    base  = wr_count;
    if (tests[n].has_store)
    begin
      wait_first_write(tests[n].name, base);
      check_word(tests[n].name, "store address", tests[n].exp_adr, wr_adr);
      check_word(tests[n].name, "store data", tests[n].exp_dat, wr_dat);
      check_sel(tests[n].name, "store select", tests[n].exp_sel, wr_sel);
    end
    wait_halt(tests[n].name);
    check_quiet(tests[n].name);
    if (!tests[n].has_store)
      check_word(tests[n].name, "data write count", '0, word_t'(wr_count - base));
  endtask

  initial
  begin
    rst_i = 1'b1;
    build_table();
    for (int n = 0; n < tests.size(); n++)
      run_entry(n);
    if (error_count == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire
